//--- hw/exc_macros.svh
// Exception handler constants.
// Vector numbers, stack frame sizes, reset read offsets and pipe depth.
`ifndef EXC_MACROS_SVH
`define EXC_MACROS_SVH

// ------------------------------------------------------------
// Vector numbers.
// ------------------------------------------------------------
`define EXC_VEC_RESET      8'd0
`define EXC_VEC_ILLEGAL    8'd4
`define EXC_VEC_DIVZERO    8'd5
`define EXC_VEC_CHK        8'd6
`define EXC_VEC_TRAPCC     8'd7   // TRAPV uses the same vector.
`define EXC_VEC_PRIV       8'd8
`define EXC_VEC_TRACE      8'd9
`define EXC_VEC_1010       8'd10
`define EXC_VEC_1111       8'd11
`define EXC_VEC_AUTO       8'd24  // Autovector base, level added.
`define EXC_VEC_TRAP_BASE  8'd32  // TRAP #0.

// ------------------------------------------------------------
// Stack frames and reset.
// ------------------------------------------------------------
`define EXC_FRAME0_LONGS   3'd2   // SR/PC, format/vector word.
`define EXC_FRAME2_LONGS   3'd3   // Plus instruction address.

`define EXC_RESET_ISP_OFFS 32'h0000_0000
`define EXC_RESET_PC_OFFS  32'h0000_0004

// Opcode words fetched before the pipe counts as full.
`define EXC_PIPE_DEPTH     2'd3

`endif

//--- hw/exc_pkg.sv
// Exception handler types.
// States, exception classes, bus sizes and the grouped request signals.
package excPkg;

    // Sequencer states.
    typedef enum logic [3:0] {
        stIdle,
        stInit,
        stCalcVect,
        stGetVector,
        stBuildStack,
        stUpdatePc,
        stRestoreIsp,
        stRestorePc,
        stRefillPipe
    } excState_t;

    // Listed in priority order, highest first after excNone.
    typedef enum logic [3:0] {
        excNone,
        excReset,
        excChk,
        excTrapCc,
        excDivZero,
        excTrap,
        excTrapV,
        excIllegal,
        excLine1010,
        excLine1111,
        excPriv,
        excTrace,
        excInterrupt
    } exception_t;

    // SIZ encoding of the 68030 bus.
    typedef enum logic [1:0] {
        szLong = 2'b00,
        szByte = 2'b01,
        szWord = 2'b10
    } opSize_t;

    // ------------------------------------------------------------
    // Grouped signals.
    // ------------------------------------------------------------
    typedef struct packed {
        logic       chk;
        logic       trapCc;
        logic       divZero;
        logic       trap;
        logic       trapV;
        logic       illegal;
        logic       line1010;
        logic       line1111;
        logic       priv;
        logic       trace;
        logic [3:0] trapVector;  // TRAP #n operand.
    } trapReq_t;

    typedef struct packed {
        logic        read;
        logic        write;
        logic        cpuSpace;   // Interrupt acknowledge cycle.
        opSize_t     size;
        logic [31:0] addr;
    } busReq_t;

    typedef struct packed {
        logic srInit;
        logic pcInc;
        logic pcLoad;
        logic ispLoad;
        logic pcRestore;
        logic ipipeFlush;
        logic ipipeFill;
    } coreCtl_t;

endpackage

//--- hw/excPending.sv
// Pending exception tracker.
// Latches trap and interrupt requests and picks the next one by priority.
`timescale 1ns/1ps

module excPending import excPkg::*; (
    input  logic       CLK,
    input  logic       DATA_RDY,
    input  trapReq_t   trapReq,
    input  logic [2:0] irqLevel,
    input  logic [2:0] srMask,
    input  logic       intTrig,
    input  logic       accept,
    input  logic       done,
    output logic       hasPending,
    output exception_t curExc,
    output logic [2:0] irqPend,
    output logic [2:0] pendMask
);

    logic [excInterrupt:excReset] pend;   // One flag per exception class.
    exception_t                   pick;
    exception_t                   curReg;
    logic [2:0]                   irqLevelD;
    logic [2:0]                   pendLevel;
    logic                         intReq;

    // Level 7 is taken on its rising step, whatever the mask.
    assign intReq = (intTrig && (irqLevel > srMask)) ||
                    ((irqLevel == 3'd7) && (irqLevelD != 3'd7));

    // ------------------------------------------------------------
    // Priority pick. Enum order is the priority order.
    // ------------------------------------------------------------
    always_comb begin
        pick = excNone;
        for (int i = excInterrupt; i >= excReset; i--) begin
            if (pend[i]) begin
                pick = exception_t'(i);
            end
        end
    end

    assign hasPending = (pick != excNone);
    assign curExc     = (curReg == excNone) ? pick : curReg;  // Idle shows the pick.
    assign pendMask   = (curReg == excInterrupt) ? irqPend : srMask;

    always_ff @(posedge CLK or posedge DATA_RDY) begin
        if (DATA_RDY) begin
            pend           <= '0;
            pend[excReset] <= 1'b1;   // Reset exception runs first.
        end else begin
            if (accept && hasPending) begin
                pend[pick] <= 1'b0;
            end
            // New requests win over a clear in the same cycle.
            if (trapReq.chk)      pend[excChk]       <= 1'b1;
            if (trapReq.trapCc)   pend[excTrapCc]    <= 1'b1;
            if (trapReq.divZero)  pend[excDivZero]   <= 1'b1;
            if (trapReq.trap)     pend[excTrap]      <= 1'b1;
            if (trapReq.trapV)    pend[excTrapV]     <= 1'b1;
            if (trapReq.illegal)  pend[excIllegal]   <= 1'b1;
            if (trapReq.line1010) pend[excLine1010]  <= 1'b1;
            if (trapReq.line1111) pend[excLine1111]  <= 1'b1;
            if (trapReq.priv)     pend[excPriv]      <= 1'b1;
            if (trapReq.trace)    pend[excTrace]     <= 1'b1;
            if (intReq)           pend[excInterrupt] <= 1'b1;
        end
    end

    // Interrupt level capture.
    always_ff @(posedge CLK or posedge DATA_RDY) begin
        if (DATA_RDY) begin
            irqLevelD <= 3'd7;   // No level 7 step right out of reset.
            pendLevel <= 3'd0;
            irqPend   <= 3'd0;
        end else begin
            irqLevelD <= irqLevel;
            if (intReq) begin
                pendLevel <= irqLevel;
            end
            if (accept && (pick == excInterrupt)) begin
                irqPend <= pendLevel;   // Level of the interrupt in service.
            end
        end
    end

    // Current exception.
    always_ff @(posedge CLK or posedge DATA_RDY) begin
        if (DATA_RDY) begin
            curReg <= excNone;
        end else if (accept) begin
            curReg <= pick;
        end else if (done) begin
            curReg <= excNone;
        end
    end

endmodule

//--- hw/excVector.sv
// Vector calculator.
// Holds the vector base register and forms the vector table address.
`timescale 1ns/1ps
`include "exc_macros.svh"

module excVector import excPkg::*; (
    input  logic        CLK,
    input  logic        DATA_RDY,
    input  logic        vbrWr,
    input  logic [31:0] dataIn,
    input  exception_t  curExc,
    input  logic [3:0]  trapVector,
    input  logic [2:0]  irqPend,
    input  logic        ackVector,
    input  logic        busAck,
    input  logic        autoVector,
    output logic [31:0] vecAddr,
    output logic [31:0] vbr
);

    logic [7:0] vecNum;
    logic       vecLoad;

    always_comb begin
        case (curExc)
            excChk:                 vecNum = `EXC_VEC_CHK;
            excTrapCc, excTrapV:    vecNum = `EXC_VEC_TRAPCC;
            excDivZero:             vecNum = `EXC_VEC_DIVZERO;
            excTrap:                vecNum = `EXC_VEC_TRAP_BASE + {4'd0, trapVector};
            excIllegal:             vecNum = `EXC_VEC_ILLEGAL;
            excLine1010:            vecNum = `EXC_VEC_1010;
            excLine1111:            vecNum = `EXC_VEC_1111;
            excPriv:                vecNum = `EXC_VEC_PRIV;
            excTrace:               vecNum = `EXC_VEC_TRACE;
            excInterrupt: begin
                if (autoVector) begin
                    vecNum = `EXC_VEC_AUTO + {5'd0, irqPend};
                end else begin
                    vecNum = dataIn[7:0];   // Vector byte from the device.
                end
            end
            default:                vecNum = `EXC_VEC_RESET;
        endcase
    end

    // Interrupts wait for the acknowledge cycle to end.
    assign vecLoad = ackVector && ((curExc != excInterrupt) || busAck);

    always_ff @(posedge CLK or posedge DATA_RDY) begin
        if (DATA_RDY) begin
            vbr <= 32'd0;
        end else if (vbrWr) begin
            vbr <= dataIn;
        end
    end

    always_ff @(posedge CLK) begin
        if (vecLoad) begin
            vecAddr <= vbr + {22'd0, vecNum, 2'b00};
        end
    end

endmodule

//--- hw/excSequencer.sv
// Exception sequencer.
// Runs the exception FSM, its bus cycles, the stack frame and the pipe refill.
`timescale 1ns/1ps
`include "exc_macros.svh"

module excSequencer import excPkg::*; (
    input  logic        CLK,
    input  logic        DATA_RDY,
    input  logic        hasPending,
    input  logic        coreBusy,
    input  exception_t  curExc,
    input  logic        busAck,
    input  logic        opcodeRdy,
    input  logic [31:0] vecAddr,
    output logic        accept,
    output logic        done,
    output logic        ackVector,
    output busReq_t     busReq,
    output coreCtl_t    ctl,
    output logic [3:0]  stackFormat,
    output logic [2:0]  stackPos,
    output logic        busy
);

    excState_t  state;
    excState_t  nextState;
    logic [3:0] frameFmt;
    logic [2:0] frameTop;    // Index of the first long written.
    logic       incClass;
    logic [1:0] pipeCnt;
    logic       stackEntry;

    // ------------------------------------------------------------
    // Frame format and PC advance per exception class.
    // ------------------------------------------------------------
    always_comb begin
        case (curExc)
            excInterrupt, excTrap, excIllegal, excLine1010, excLine1111, excPriv: begin
                frameFmt = 4'h0;
                frameTop = `EXC_FRAME0_LONGS - 3'd1;
            end
            default: begin
                frameFmt = 4'h2;
                frameTop = `EXC_FRAME2_LONGS - 3'd1;
            end
        endcase
    end

    always_comb begin
        case (curExc)
            excChk, excTrapCc, excDivZero, excTrap, excTrapV, excInterrupt: incClass = 1'b1;
            default: incClass = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // Next state.
    // ------------------------------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                // Reset does not wait for the core.
                if (hasPending && (!coreBusy || (curExc == excReset))) begin
                    nextState = stInit;
                end
            end
            stInit: begin
                if (curExc == excInterrupt) begin
                    nextState = stGetVector;
                end else begin
                    nextState = stCalcVect;
                end
            end
            stCalcVect: begin
                if (curExc == excReset) begin
                    nextState = stRestoreIsp;
                end else begin
                    nextState = stBuildStack;
                end
            end
            stGetVector:  if (busAck) nextState = stBuildStack;
            stBuildStack: if (busAck && (stackPos == 3'd0)) nextState = stUpdatePc;
            stUpdatePc:   if (busAck) nextState = stRefillPipe;
            stRestoreIsp: if (busAck) nextState = stRestorePc;
            stRestorePc:  if (busAck) nextState = stRefillPipe;
            stRefillPipe: begin
                if (opcodeRdy && (pipeCnt == `EXC_PIPE_DEPTH - 2'd1)) begin
                    nextState = stIdle;
                end
            end
            default: nextState = stIdle;
        endcase
    end

    assign stackEntry = (state != stBuildStack) && (nextState == stBuildStack);

    always_ff @(posedge CLK or posedge DATA_RDY) begin
        if (DATA_RDY) begin
            state       <= stIdle;
            stackPos    <= 3'd0;
            stackFormat <= 4'h0;
            pipeCnt     <= 2'd0;
        end else begin
            state <= nextState;
            if (stackEntry) begin
                stackPos    <= frameTop;
                stackFormat <= frameFmt;
            end else if ((state == stBuildStack) && busAck && (stackPos != 3'd0)) begin
                stackPos <= stackPos - 3'd1;   // Next long down.
            end
            if (state != stRefillPipe) begin
                pipeCnt <= 2'd0;
            end else if (opcodeRdy) begin
                pipeCnt <= pipeCnt + 2'd1;
            end
        end
    end

    assign accept    = (state == stIdle) && (nextState == stInit);
    assign done      = (state == stRefillPipe) && (nextState == stIdle);
    assign ackVector = (state == stCalcVect) || (state == stGetVector);
    assign busy      = (state != stIdle);

    // ------------------------------------------------------------
    // Bus request, decoded from the state.
    // ------------------------------------------------------------
    always_comb begin
        busReq      = '0;
        busReq.size = szLong;
        case (state)
            stGetVector: begin
                busReq.read     = 1'b1;
                busReq.cpuSpace = 1'b1;
                busReq.size     = szByte;   // Vector byte only.
            end
            stBuildStack: begin
                busReq.write = 1'b1;
                busReq.addr  = {27'd0, stackPos, 2'b00};
            end
            stUpdatePc: begin
                busReq.read = 1'b1;
                busReq.addr = vecAddr;
            end
            stRestoreIsp: begin
                busReq.read = 1'b1;
                busReq.addr = `EXC_RESET_ISP_OFFS;
            end
            stRestorePc: begin
                busReq.read = 1'b1;
                busReq.addr = `EXC_RESET_PC_OFFS;
            end
            default: ;
        endcase
    end

    // Core strobes.
    always_comb begin
        ctl.srInit     = (state == stInit);
        ctl.pcInc      = incClass && stackEntry;
        ctl.pcLoad     = (state == stUpdatePc) && busAck;
        ctl.ispLoad    = (state == stRestoreIsp) && busAck;
        ctl.pcRestore  = (state == stRestorePc) && busAck;
        ctl.ipipeFlush = (state == stInit) || ((curExc == excReset) && busy);
        ctl.ipipeFill  = (state == stRefillPipe);
    end

endmodule

//--- hw/excHandler.sv
// Exception handler top level.
// Pending tracker, vector calculator and bus sequencer.
`timescale 1ns/1ps

module excHandler import excPkg::*; (
    input  logic        CLK,
    input  logic        DATA_RDY,
    input  trapReq_t    trapReq,
    input  logic [2:0]  irqLevel,
    input  logic        intTrig,
    input  logic [2:0]  srMask,
    input  logic        coreBusy,
    input  logic        vbrWr,
    input  logic [31:0] dataIn,
    input  logic        opcodeRdy,
    input  logic        busAck,
    input  logic        autoVector,
    output busReq_t     busReq,
    output coreCtl_t    ctl,
    output logic [3:0]  stackFormat,
    output logic [2:0]  stackPos,
    output logic        busy,
    output logic [2:0]  irqPend,   // Interrupt level in service, else SR mask.
    output logic [31:0] vbr
);

    logic        hasPending;
    logic        accept;
    logic        done;
    logic        ackVector;
    exception_t  curExc;
    logic [2:0]  irqCur;
    logic [31:0] vecAddr;

    excPending u_pending (
        .CLK        (CLK),
        .DATA_RDY   (DATA_RDY),
        .trapReq    (trapReq),
        .irqLevel   (irqLevel),
        .srMask     (srMask),
        .intTrig    (intTrig),
        .accept     (accept),
        .done       (done),
        .hasPending (hasPending),
        .curExc     (curExc),
        .irqPend    (irqCur),
        .pendMask   (irqPend)
    );

    excVector u_vector (
        .CLK        (CLK),
        .DATA_RDY   (DATA_RDY),
        .vbrWr      (vbrWr),
        .dataIn     (dataIn),
        .curExc     (curExc),
        .trapVector (trapReq.trapVector),
        .irqPend    (irqCur),
        .ackVector  (ackVector),
        .busAck     (busAck),
        .autoVector (autoVector),
        .vecAddr    (vecAddr),
        .vbr        (vbr)
    );

    excSequencer u_seq (
        .CLK         (CLK),
        .DATA_RDY    (DATA_RDY),
        .hasPending  (hasPending),
        .coreBusy    (coreBusy),
        .curExc      (curExc),
        .busAck      (busAck),
        .opcodeRdy   (opcodeRdy),
        .vecAddr     (vecAddr),
        .accept      (accept),
        .done        (done),
        .ackVector   (ackVector),
        .busReq      (busReq),
        .ctl         (ctl),
        .stackFormat (stackFormat),
        .stackPos    (stackPos),
        .busy        (busy)
    );

endmodule

//--- testbench/excHandler_sva.sv
// Exception handler bus checks.
// Request exclusivity, interrupt acknowledge shape and busy after reset.
`timescale 1ns/1ps

module excHandler_sva import excPkg::*; (
    input logic    CLK,
    input logic    DATA_RDY,
    input busReq_t busReq,
    input logic    busy
);

    int failCount = 0;   // Assertion failures so far.

    rdWrExclusive: assert property (@(posedge CLK) disable iff (DATA_RDY)
        !(busReq.read && busReq.write))
        else begin
            $error("bus read and write requested in the same cycle");
            failCount++;
        end

    // Interrupt acknowledge is a byte read.
    cpuSpaceByteRead: assert property (@(posedge CLK) disable iff (DATA_RDY)
        busReq.cpuSpace |-> (busReq.read && (busReq.size == szByte)))
        else begin
            $error("cpu space cycle is not a byte read");
            failCount++;
        end

    idleAfterReset: assert property (@(posedge CLK) $fell(DATA_RDY) |-> !busy)
        else begin
            $error("busy set in the first cycle after reset");
            failCount++;
        end

endmodule

//--- testbench/tb_excHandler.sv
// Exception handler testbench.
// Bus responder, pipe responder and a table of exception cases.
`timescale 1ns/1ps
`include "exc_macros.svh"

module tb_excHandler import excPkg::*; ();

    localparam int NUM_ROWS = 17;

    typedef enum {
        kReset, kChk, kTrapCc, kDivZero, kTrap, kTrapV, kIllegal, kLine1010,
        kLine1111, kPriv, kTrace, kIrqTrig, kIrqStep7, kTraceTrap, kFollow
    } testKind_t;

    typedef struct {
        string       name;
        testKind_t   kind;
        logic [31:0] vbrVal;
        logic [3:0]  trapVec;
        logic [2:0]  level;
        logic [2:0]  mask;
        logic        autoVec;
        logic [7:0]  vecByte;
        logic [31:0] expAddr;     // Address of the PC read.
        int          expWrites;
        logic [3:0]  expFormat;
        int          expPcInc;
    } testRow_t;

    logic        CLK;
    logic        DATA_RDY;
    trapReq_t    trapReq;
    logic [2:0]  irqLevel;
    logic        intTrig;
    logic [2:0]  srMask;
    logic        coreBusy;
    logic        vbrWr;
    logic [31:0] dataIn;
    logic        opcodeRdy;
    logic        busAck;
    logic        autoVector;
    busReq_t     busReq;
    coreCtl_t    ctl;
    logic [3:0]  stackFormat;
    logic [2:0]  stackPos;
    logic        busy;
    logic [2:0]  irqPend;
    logic [31:0] vbr;

    testRow_t    rows [NUM_ROWS];
    logic [31:0] lfsr = 32'hceb53c15;
    logic [7:0]  vecByte;
    logic        armed;
    int          ackWait;
    int          errors, passCnt, failCnt, svaFails;
    int          writeCnt, readCnt, cpuReadCnt, pcIncCnt, pcLoadCnt, ispLoadCnt, pcRestoreCnt;
    int          srInitCnt, flushCnt, fillCnt, busyCnt;
    logic [31:0] firstRead, lastRead;
    logic [3:0]  lastFormat;
    logic [2:0]  wrPos [$];    // Stack position at each write.
    logic [31:0] wrAddr [$];
    logic [2:0]  ackLevel;     // Level output during the acknowledge.

    excHandler u_dut (.*);

    bind excHandler excHandler_sva u_sva (
        .CLK(CLK), .DATA_RDY(DATA_RDY), .busReq(busReq), .busy(busy)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Galois LFSR, one step per bit taken.
    function automatic int randBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // ------------------------------------------------------------
    // Responders and monitor.
    // ------------------------------------------------------------
    initial begin
        forever begin
            @(negedge CLK);
            if (busAck) begin
                busAck = 1'b0;   // One-cycle pulse.
                armed  = 1'b0;
            end else if (busReq.read || busReq.write) begin
                if (!armed) begin
                    armed   = 1'b1;
                    ackWait = 1 + randBits(2);
                end
                ackWait--;
                if (ackWait == 0) begin
                    busAck = 1'b1;
                    dataIn = busReq.cpuSpace ? {24'd0, vecByte} : (busReq.addr | 32'h0001_0000);
                end
            end
        end
    end

    initial begin
        forever begin
            @(negedge CLK);
            opcodeRdy = ctl.ipipeFill;   // One opcode word per cycle.
        end
    end

    // Sampled mid low phase, where inputs and outputs are settled.
    initial begin
        forever begin
            @(negedge CLK);
            #5;
            if (busAck && busReq.write) begin
                writeCnt++;
                lastFormat = stackFormat;
                wrPos.push_back(stackPos);
                wrAddr.push_back(busReq.addr);
            end
            if (busAck && busReq.read && busReq.cpuSpace) begin
                cpuReadCnt++;
                ackLevel = irqPend;
            end
            if (busAck && busReq.read && !busReq.cpuSpace) begin
                if (readCnt == 0) firstRead = busReq.addr;
                lastRead = busReq.addr;
                readCnt++;
            end
            if (ctl.pcInc) pcIncCnt++;
            if (ctl.pcLoad) pcLoadCnt++;
            if (ctl.ispLoad) ispLoadCnt++;
            if (ctl.pcRestore) pcRestoreCnt++;
            if (ctl.srInit) srInitCnt++;
            if (ctl.ipipeFlush) flushCnt++;
            if (ctl.ipipeFill) fillCnt++;
            if (busy) busyCnt++;
        end
    end

    initial begin
        repeat (NUM_ROWS * 200) @(posedge CLK);
        $display("watchdog: tests did not finish within %0d cycles", NUM_ROWS * 200);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Tasks.
    // ------------------------------------------------------------
    task automatic reportMismatch(input string name, input string what,
                                  input logic [31:0] expVal, input logic [31:0] actVal);
        $display("FAILED %s %s expected 0x%0h actual 0x%0h", name, what, expVal, actVal);
        errors++;
    endtask

    task automatic reportProblem(input string name, input string what);
        $display("ERROR in %s: %s", name, what);
        errors++;
    endtask

    task automatic waitBusy(input logic level, input int limit, output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && (n < limit)) begin
            @(negedge CLK);
            ok = (busy == level);
            n++;
        end
    endtask

    task automatic applyRow(input testRow_t r);
        vecByte = r.vecByte;
        if ((r.kind != kReset) && (r.kind != kFollow)) begin
            @(negedge CLK);
            vbrWr              = 1'b1;
            dataIn             = r.vbrVal;
            srMask             = r.mask;
            autoVector         = r.autoVec;
            trapReq.trapVector = r.trapVec;   // Held for the whole exception.
            @(negedge CLK);
            vbrWr = 1'b0;
            case (r.kind)
                kChk:       trapReq.chk = 1'b1;
                kTrapCc:    trapReq.trapCc = 1'b1;
                kDivZero:   trapReq.divZero = 1'b1;
                kTrap:      trapReq.trap = 1'b1;
                kTrapV:     trapReq.trapV = 1'b1;
                kIllegal:   trapReq.illegal = 1'b1;
                kLine1010:  trapReq.line1010 = 1'b1;
                kLine1111:  trapReq.line1111 = 1'b1;
                kPriv:      trapReq.priv = 1'b1;
                kTrace:     trapReq.trace = 1'b1;
                kIrqStep7:  irqLevel = 3'd7;
                kTraceTrap: begin
                    trapReq.trace   = 1'b1;
                    trapReq.divZero = 1'b1;
                end
                default: begin
                    irqLevel = r.level;
                    intTrig  = 1'b1;
                end
            endcase
            @(negedge CLK);
            trapReq            = '0;
            trapReq.trapVector = r.trapVec;
            intTrig            = 1'b0;
        end
    endtask

    task automatic runRow(input testRow_t r);
        int   errBefore;
        logic ok;
        logic seen;
        logic isReset;
        logic isIrq;
        errBefore = errors;
        isReset   = (r.kind == kReset);
        isIrq     = (r.kind == kIrqTrig) || (r.kind == kIrqStep7);
        {writeCnt, readCnt, cpuReadCnt, pcIncCnt} = '0;
        {pcLoadCnt, ispLoadCnt, pcRestoreCnt} = '0;
        {srInitCnt, flushCnt, fillCnt, busyCnt} = '0;
        wrPos.delete();
        wrAddr.delete();
        applyRow(r);
        if ((r.kind == kIrqTrig) && (r.level <= r.mask)) begin
            seen = 1'b0;
            repeat (20) begin
                @(negedge CLK);
                if (busy) seen = 1'b1;
            end
            if (seen) reportProblem(r.name, "interrupt at or below the mask was taken");
        end else begin
            waitBusy(1'b1, 40, ok);
            if (!ok) begin
                reportProblem(r.name, "exception never started");
            end else begin
                waitBusy(1'b0, 200, ok);
                if (!ok) reportProblem(r.name, "exception never finished");
            end
            if (writeCnt != r.expWrites) reportMismatch(r.name, "writes", r.expWrites, writeCnt);
            if ((r.expWrites != 0) && (lastFormat != r.expFormat))
                reportMismatch(r.name, "stack format", r.expFormat, lastFormat);
            // Frame is written from the top long down to offset 0.
            for (int i = 0; i < wrPos.size(); i++) begin
                if (wrPos[i] != (r.expWrites - 1 - i))
                    reportMismatch(r.name, "stack position", r.expWrites - 1 - i, wrPos[i]);
                if (wrAddr[i] != 4 * (r.expWrites - 1 - i))
                    reportMismatch(r.name, "stack write address",
                                   4 * (r.expWrites - 1 - i), wrAddr[i]);
            end
            if (lastRead != r.expAddr) reportMismatch(r.name, "vector address", r.expAddr, lastRead);
            if (readCnt != (isReset ? 2 : 1)) reportMismatch(r.name, "reads", isReset ? 2 : 1, readCnt);
            if (isReset && (firstRead != `EXC_RESET_ISP_OFFS))
                reportMismatch(r.name, "isp read address", `EXC_RESET_ISP_OFFS, firstRead);
            if (cpuReadCnt != (isIrq ? 1 : 0))
                reportMismatch(r.name, "cpu space reads", isIrq ? 1 : 0, cpuReadCnt);
            if (isIrq && (ackLevel != r.level))
                reportMismatch(r.name, "acknowledge level", r.level, ackLevel);
            if (pcIncCnt != r.expPcInc) reportMismatch(r.name, "pcInc", r.expPcInc, pcIncCnt);
            if (pcLoadCnt != (isReset ? 0 : 1))
                reportMismatch(r.name, "pcLoad", isReset ? 0 : 1, pcLoadCnt);
            if (ispLoadCnt != (isReset ? 1 : 0))
                reportMismatch(r.name, "ispLoad", isReset ? 1 : 0, ispLoadCnt);
            if (pcRestoreCnt != (isReset ? 1 : 0))
                reportMismatch(r.name, "pcRestore", isReset ? 1 : 0, pcRestoreCnt);
            if (srInitCnt != 1) reportMismatch(r.name, "srInit", 1, srInitCnt);
            if (fillCnt != `EXC_PIPE_DEPTH)
                reportMismatch(r.name, "ipipeFill cycles", `EXC_PIPE_DEPTH, fillCnt);
            // Reset keeps the pipe flushed while busy, others flush in init only.
            if (flushCnt != (isReset ? busyCnt : 1))
                reportMismatch(r.name, "ipipeFlush cycles", isReset ? busyCnt : 1, flushCnt);
        end
        if (vbr != r.vbrVal) reportMismatch(r.name, "vbr", r.vbrVal, vbr);
        if (irqPend != r.mask) reportMismatch(r.name, "mask output", r.mask, irqPend);
        irqLevel = 3'd0;
        if (errors == errBefore) begin
            passCnt++;
            $display("test %-12s ok", r.name);
        end else begin
            failCnt++;
            $display("test %-12s failed, %0d errors", r.name, errors - errBefore);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus table and main sequence.
    // ------------------------------------------------------------
    initial begin
        DATA_RDY   = 1'b1;
        trapReq    = '0;
        irqLevel   = 3'd0;
        intTrig    = 1'b0;
        srMask     = 3'd7;
        coreBusy   = 1'b0;
        vbrWr      = 1'b0;
        dataIn     = 32'd0;
        opcodeRdy  = 1'b0;
        busAck     = 1'b0;
        autoVector = 1'b0;
        armed      = 1'b0;
        ackWait    = 0;
        vecByte    = 8'd0;
        ackLevel   = 3'd0;
        {errors, passCnt, failCnt} = '0;

        rows[0]  = '{"reset", kReset, 32'h0, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     `EXC_RESET_PC_OFFS, 0, 4'h0, 0};
        rows[1]  = '{"chk", kChk, 32'h1000, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h1000 + 4 * `EXC_VEC_CHK, 3, 4'h2, 1};
        rows[2]  = '{"trapcc", kTrapCc, 32'h1000, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h1000 + 4 * `EXC_VEC_TRAPCC, 3, 4'h2, 1};
        rows[3]  = '{"divzero", kDivZero, 32'h2000, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h2000 + 4 * `EXC_VEC_DIVZERO, 3, 4'h2, 1};
        rows[4]  = '{"trap5", kTrap, 32'h2000, 4'd5, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h2000 + 4 * (`EXC_VEC_TRAP_BASE + 5), 2, 4'h0, 1};
        rows[5]  = '{"trapv", kTrapV, 32'h2400, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h2400 + 4 * `EXC_VEC_TRAPCC, 3, 4'h2, 1};
        rows[6]  = '{"illegal", kIllegal, 32'h2400, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h2400 + 4 * `EXC_VEC_ILLEGAL, 2, 4'h0, 0};
        rows[7]  = '{"line1010", kLine1010, 32'h5000, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h5000 + 4 * `EXC_VEC_1010, 2, 4'h0, 0};
        rows[8]  = '{"line1111", kLine1111, 32'h5000, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h5000 + 4 * `EXC_VEC_1111, 2, 4'h0, 0};
        rows[9]  = '{"priv", kPriv, 32'h6000, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h6000 + 4 * `EXC_VEC_PRIV, 2, 4'h0, 0};
        rows[10] = '{"trace", kTrace, 32'h8000, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h8000 + 4 * `EXC_VEC_TRACE, 3, 4'h2, 0};
        rows[11] = '{"irq_masked", kIrqTrig, 32'h3000, 4'd0, 3'd3, 3'd3, 1'b1, 8'h00,
                     32'h0, 0, 4'h0, 0};
        rows[12] = '{"irq_auto", kIrqTrig, 32'h3000, 4'd0, 3'd5, 3'd2, 1'b1, 8'h00,
                     32'h3000 + 4 * (`EXC_VEC_AUTO + 5), 2, 4'h0, 1};
        rows[13] = '{"irq_vectored", kIrqTrig, 32'h3000, 4'd0, 3'd4, 3'd0, 1'b0, 8'h40,
                     32'h3000 + 4 * 8'h40, 2, 4'h0, 1};
        rows[14] = '{"irq_level7", kIrqStep7, 32'h3800, 4'd0, 3'd7, 3'd7, 1'b1, 8'h00,
                     32'h3800 + 4 * (`EXC_VEC_AUTO + 7), 2, 4'h0, 1};
        rows[15] = '{"prio_trap", kTraceTrap, 32'h4000, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h4000 + 4 * `EXC_VEC_DIVZERO, 3, 4'h2, 1};
        rows[16] = '{"prio_trace", kFollow, 32'h4000, 4'd0, 3'd0, 3'd7, 1'b0, 8'h00,
                     32'h4000 + 4 * `EXC_VEC_TRACE, 3, 4'h2, 0};

        repeat (10) @(negedge CLK);
        DATA_RDY = 1'b0;   // Reset exception starts the table.
        for (int i = 0; i < NUM_ROWS; i++) begin
            runRow(rows[i]);
        end

        svaFails = u_dut.u_sva.failCount;
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 NUM_ROWS, passCnt, failCnt, svaFails);
        if ((failCnt == 0) && (svaFails == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- excHandler.f
+incdir+hw
hw/exc_pkg.sv
hw/excPending.sv
hw/excVector.sv
hw/excSequencer.sv
hw/excHandler.sv
testbench/excHandler_sva.sv
testbench/tb_excHandler.sv

//--- Bender.yml
package:
  name: excHandler

sources:
  - include_dirs:
      - hw
    files:
      - hw/exc_pkg.sv
      - hw/excPending.sv
      - hw/excVector.sv
      - hw/excSequencer.sv
      - hw/excHandler.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/excHandler_sva.sv
      - testbench/tb_excHandler.sv
